// ==== hw/cpu_pkg.sv ====
package cpu_pkg;

	localparam int data_w = 16;
	localparam int reg_idx_w = 4;
	localparam int opcode_w = 8;
	localparam int shamt_w = 5;
	localparam int flags_w = 3;

	// composite opcode {instr[15:12], instr[7:4]}
	// immediate forms carry a zero low nibble and are matched on the upper nibble only
	typedef enum logic [opcode_w-1:0] {
		op_and   = 8'h01,
		op_or    = 8'h02,
		op_xor   = 8'h03,
		op_add   = 8'h05,
		op_sub   = 8'h09,
		op_cmp   = 8'h0b,
		op_mov   = 8'h0d,
		op_mul   = 8'h0e,
		op_andi  = 8'h10,
		op_ori   = 8'h20,
		op_xori  = 8'h30,
		op_load  = 8'h40,
		op_store = 8'h44,
		op_addi  = 8'h50,
		op_lshi  = 8'h80,
		op_lsh   = 8'h84,
		op_ashu  = 8'h86,
		op_subi  = 8'h90,
		op_cmpi  = 8'hb0,
		op_movi  = 8'hd0,
		op_muli  = 8'he0,
		op_lui   = 8'hf0
	} opcode_e;

	typedef enum logic [3:0] {
		add, sub, mul, and_op, or_op, xor_op, mov, lui, lsh, ashu
	} alu_op_e;

	typedef enum logic [2:0] {
		alu_reg,
		alu_imm,
		load,
		store,
		illegal
	} instr_class_e;

	// composite opcode 8'h00 is unused, so this word stops the core
	localparam logic [data_w-1:0] halt_word = 16'h0000;

endpackage

// ==== hw/instr_decoder.sv ====
`timescale 1ns/10ps

module instr_decoder (
	input  logic [cpu_pkg::data_w-1:0]    instr,
	output logic [cpu_pkg::reg_idx_w-1:0] rd_idx,
	output logic [cpu_pkg::reg_idx_w-1:0] rs_idx,
	output cpu_pkg::alu_op_e              alu_op,
	output cpu_pkg::instr_class_e         instr_class,
	output logic [cpu_pkg::data_w-1:0]    imm,
	output logic                          is_cmp
);

	logic [cpu_pkg::opcode_w-1:0] op;
	logic [7:0]                   imm_byte;
	logic [cpu_pkg::data_w-1:0]   imm_sext;
	logic [cpu_pkg::data_w-1:0]   imm_zext;

	assign op = {instr[15:12], instr[7:4]};
	assign rd_idx = instr[11:8];
	assign rs_idx = instr[3:0];

	// the immediate byte spans the op extension and rs fields
	assign imm_byte = instr[7:0];
	assign imm_sext = {{8{imm_byte[7]}}, imm_byte};
	assign imm_zext = {8'h00, imm_byte};

	always_comb
	begin
		alu_op = cpu_pkg::mov;
		instr_class = cpu_pkg::alu_reg;
		imm = '0;
		is_cmp = 1'b0;
		case (op)
			cpu_pkg::op_add:   alu_op = cpu_pkg::add;
			cpu_pkg::op_sub:   alu_op = cpu_pkg::sub;
			cpu_pkg::op_mul:   alu_op = cpu_pkg::mul;
			cpu_pkg::op_and:   alu_op = cpu_pkg::and_op;
			cpu_pkg::op_or:    alu_op = cpu_pkg::or_op;
			cpu_pkg::op_xor:   alu_op = cpu_pkg::xor_op;
			cpu_pkg::op_mov:   alu_op = cpu_pkg::mov;
			cpu_pkg::op_lsh:   alu_op = cpu_pkg::lsh;
			cpu_pkg::op_ashu:  alu_op = cpu_pkg::ashu;
			cpu_pkg::op_load:  instr_class = cpu_pkg::load;
			cpu_pkg::op_store: instr_class = cpu_pkg::store;
			cpu_pkg::op_cmp:
			begin
				alu_op = cpu_pkg::sub;
				is_cmp = 1'b1;
			end
			default:
			begin
				// immediate forms, only the upper nibble is significant
				instr_class = cpu_pkg::alu_imm;
				imm = imm_zext;
				case ({op[7:4], 4'h0})
					cpu_pkg::op_andi: alu_op = cpu_pkg::and_op;
					cpu_pkg::op_ori:  alu_op = cpu_pkg::or_op;
					cpu_pkg::op_xori: alu_op = cpu_pkg::xor_op;
					cpu_pkg::op_movi: alu_op = cpu_pkg::mov;
					cpu_pkg::op_lshi: alu_op = cpu_pkg::lsh;
					cpu_pkg::op_addi:
					begin
						alu_op = cpu_pkg::add;
						imm = imm_sext;
					end
					cpu_pkg::op_subi:
					begin
						alu_op = cpu_pkg::sub;
						imm = imm_sext;
					end
					cpu_pkg::op_muli:
					begin
						alu_op = cpu_pkg::mul;
						imm = imm_sext;
					end
					cpu_pkg::op_cmpi:
					begin
						alu_op = cpu_pkg::sub;
						imm = imm_sext;
						is_cmp = 1'b1;
					end
					cpu_pkg::op_lui:
					begin
						alu_op = cpu_pkg::lui;
						imm = {imm_byte, 8'h00};
					end
					default: instr_class = cpu_pkg::illegal;
				endcase
			end
		endcase
	end

endmodule

// ==== hw/alu.sv ====
`timescale 1ns/10ps

module alu (
	input  cpu_pkg::alu_op_e           op,
	input  logic [cpu_pkg::data_w-1:0] a,
	input  logic [cpu_pkg::data_w-1:0] b,
	output logic [cpu_pkg::data_w-1:0] y,
	output logic                       zero,
	output logic                       negative,
	output logic                       carry
);

	localparam int w = cpu_pkg::data_w;
	localparam int sw = cpu_pkg::shamt_w;

	logic [w:0]     sum;
	logic [w:0]     diff;
	logic [2*w-1:0] prod;
	logic           shift_right;
	logic [sw-1:0]  shamt_mag;
	logic [w-1:0]   shl;
	logic [w-1:0]   shr;
	logic [w-1:0]   sar;

	assign sum = {1'b0, a} + {1'b0, b};
	assign diff = {1'b0, a} - {1'b0, b};
	assign prod = a * b;

	// low five bits of b are a signed shift count, negative means right
	assign shift_right = b[sw-1];
	assign shamt_mag = shift_right ? (~b[sw-1:0] + 1'b1) : b[sw-1:0];
	assign shl = a << shamt_mag;
	assign shr = a >> shamt_mag;
	assign sar = $signed(a) >>> shamt_mag;

	always_comb
	begin
		carry = 1'b0;
		case (op)
			cpu_pkg::add:
			begin
				y = sum[w-1:0];
				carry = sum[w];
			end
			cpu_pkg::sub:
			begin
				y = diff[w-1:0];
				// unsigned borrow
				carry = diff[w];
			end
			cpu_pkg::mul:    y = prod[w-1:0];
			cpu_pkg::and_op: y = a & b;
			cpu_pkg::or_op:  y = a | b;
			cpu_pkg::xor_op: y = a ^ b;
			cpu_pkg::mov:    y = b;
			// upper byte from the immediate, lower byte of rd kept
			cpu_pkg::lui:    y = {b[w-1:8], a[7:0]};
			cpu_pkg::lsh:    y = shift_right ? shr : shl;
			cpu_pkg::ashu:   y = shift_right ? sar : shl;
			default:         y = a;
		endcase
	end

	assign zero = (y == '0);
	assign negative = y[w-1];

endmodule

// ==== hw/reg_file.sv ====
`timescale 1ns/10ps

module reg_file (
	input  logic                          clk,
	input  logic                          rst,
	input  logic [cpu_pkg::reg_idx_w-1:0] ra_idx,
	input  logic [cpu_pkg::reg_idx_w-1:0] rb_idx,
	output logic [cpu_pkg::data_w-1:0]    ra_data,
	output logic [cpu_pkg::data_w-1:0]    rb_data,
	input  logic                          we,
	input  logic [cpu_pkg::reg_idx_w-1:0] w_idx,
	input  logic [cpu_pkg::data_w-1:0]    w_data
);

	logic [cpu_pkg::data_w-1:0] regs [2**cpu_pkg::reg_idx_w];

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			regs <= '{default: '0};
		end
		else if (we)
		begin
			regs[w_idx] <= w_data;
		end
	end

	// asynchronous reads
	assign ra_data = regs[ra_idx];
	assign rb_data = regs[rb_idx];

endmodule

// ==== hw/core_ctrl.sv ====
`timescale 1ns/10ps

module core_ctrl #(
	parameter int addr_w = 10
) (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        start,
	output logic                        halted,
	// {zero, negative, carry} from the last compare
	output logic [cpu_pkg::flags_w-1:0] flags,
	output logic                        core_req,
	output logic                        core_we,
	output logic [addr_w-1:0]           core_addr,
	output logic [cpu_pkg::data_w-1:0]  core_wdata,
	input  logic                        core_gnt,
	input  logic                        core_rvalid,
	input  logic [cpu_pkg::data_w-1:0]  mem_rdata
);

	typedef enum logic [2:0] {
		idle,
		fetch,
		fetch_wait,
		execute,
		data_req,
		data_wait
	} state_e;

	state_e                        state;
	logic [addr_w-1:0]             pc;
	logic [cpu_pkg::data_w-1:0]    ir;
	logic [cpu_pkg::reg_idx_w-1:0] rd_idx;
	logic [cpu_pkg::reg_idx_w-1:0] rs_idx;
	cpu_pkg::alu_op_e              alu_op;
	cpu_pkg::instr_class_e         instr_class;
	logic [cpu_pkg::data_w-1:0]    imm;
	logic                          is_cmp;
	logic [cpu_pkg::data_w-1:0]    ra_data;
	logic [cpu_pkg::data_w-1:0]    rb_data;
	logic [cpu_pkg::data_w-1:0]    alu_b;
	logic [cpu_pkg::data_w-1:0]    alu_y;
	logic                          alu_zero;
	logic                          alu_negative;
	logic                          alu_carry;
	logic                          is_alu;
	logic                          rf_we;
	logic [cpu_pkg::data_w-1:0]    rf_wdata;

	instr_decoder decoder_i (
		.instr       (ir),
		.rd_idx      (rd_idx),
		.rs_idx      (rs_idx),
		.alu_op      (alu_op),
		.instr_class (instr_class),
		.imm         (imm),
		.is_cmp      (is_cmp)
	);

	reg_file reg_file_i (
		.clk     (clk),
		.rst     (rst),
		.ra_idx  (rd_idx),
		.rb_idx  (rs_idx),
		.ra_data (ra_data),
		.rb_data (rb_data),
		.we      (rf_we),
		.w_idx   (rd_idx),
		.w_data  (rf_wdata)
	);

	alu alu_i (
		.op       (alu_op),
		.a        (ra_data),
		.b        (alu_b),
		.y        (alu_y),
		.zero     (alu_zero),
		.negative (alu_negative),
		.carry    (alu_carry)
	);

	assign is_alu = (instr_class == cpu_pkg::alu_reg) || (instr_class == cpu_pkg::alu_imm);
	assign alu_b = (instr_class == cpu_pkg::alu_imm) ? imm : rb_data;

	// compares only touch the flags
	assign rf_we = ((state == execute) && is_alu && !is_cmp) ||
		((state == data_wait) && core_rvalid);
	assign rf_wdata = (state == data_wait) ? mem_rdata : alu_y;

	// request stays up, unchanged, until granted
	assign core_req = (state == fetch) || (state == data_req);
	assign core_we = (state == data_req) && (instr_class == cpu_pkg::store);
	assign core_addr = (state == fetch) ? pc : rb_data[addr_w-1:0];
	assign core_wdata = ra_data;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= idle;
			pc <= '0;
			halted <= 1'b1;
			flags <= '0;
		end
		else if (start)
		begin
			state <= fetch;
			pc <= '0;
			halted <= 1'b0;
		end
		else
		begin
			case (state)
				fetch:
				begin
					if (core_gnt)
						state <= fetch_wait;
				end
				fetch_wait:
				begin
					if (core_rvalid)
						state <= execute;
				end
				execute:
				begin
					if (is_alu)
					begin
						if (is_cmp)
							flags <= {alu_zero, alu_negative, alu_carry};
						pc <= pc + 1'b1;
						state <= fetch;
					end
					else if ((instr_class == cpu_pkg::load) || (instr_class == cpu_pkg::store))
					begin
						pc <= pc + 1'b1;
						state <= data_req;
					end
					else
					begin
						halted <= 1'b1;
						state <= idle;
					end
				end
				data_req:
				begin
					if (core_gnt)
						state <= (instr_class == cpu_pkg::store) ? fetch : data_wait;
				end
				data_wait:
				begin
					if (core_rvalid)
						state <= fetch;
				end
				default: state <= idle;
			endcase
		end
	end

	// instruction register
	always_ff @(posedge clk)
	begin
		if ((state == fetch_wait) && core_rvalid)
			ir <= mem_rdata;
	end

endmodule

// ==== hw/mem_arbiter.sv ====
`timescale 1ns/10ps

module mem_arbiter #(
	parameter int addr_w = 10
) (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       host_req,
	input  logic                       host_we,
	input  logic [addr_w-1:0]          host_addr,
	input  logic [cpu_pkg::data_w-1:0] host_wdata,
	output logic                       host_rvalid,
	input  logic                       core_req,
	input  logic                       core_we,
	input  logic [addr_w-1:0]          core_addr,
	input  logic [cpu_pkg::data_w-1:0] core_wdata,
	output logic                       core_gnt,
	output logic                       core_rvalid,
	output logic                       mem_en,
	output logic                       mem_we,
	output logic [addr_w-1:0]          mem_addr,
	output logic [cpu_pkg::data_w-1:0] mem_wdata
);

	// host always wins, the core waits with its request held
	assign core_gnt = core_req && !host_req;

	assign mem_en = host_req || core_req;
	assign mem_we = host_req ? host_we : core_we;
	assign mem_addr = host_req ? host_addr : core_addr;
	assign mem_wdata = host_req ? host_wdata : core_wdata;

	// remember who owns the read in flight
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			host_rvalid <= 1'b0;
			core_rvalid <= 1'b0;
		end
		else
		begin
			host_rvalid <= host_req && !host_we;
			core_rvalid <= core_gnt && !core_we;
		end
	end

endmodule

// ==== hw/unified_mem.sv ====
`timescale 1ns/10ps

module unified_mem #(
	parameter int addr_w = 10
) (
	input  logic                       clk,
	input  logic                       mem_en,
	input  logic                       mem_we,
	input  logic [addr_w-1:0]          mem_addr,
	input  logic [cpu_pkg::data_w-1:0] mem_wdata,
	output logic [cpu_pkg::data_w-1:0] mem_rdata
);

	logic [cpu_pkg::data_w-1:0] ram [2**addr_w];

	// one-cycle read latency, rdata holds between reads
	always_ff @(posedge clk)
	begin
		if (mem_en)
		begin
			if (mem_we)
				ram[mem_addr] <= mem_wdata;
			else
				mem_rdata <= ram[mem_addr];
		end
	end

endmodule

// ==== hw/cpu_top.sv ====
`timescale 1ns/10ps

module cpu_top #(
	parameter int addr_w = 10
) (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        host_req,
	input  logic                        host_we,
	input  logic [addr_w-1:0]           host_addr,
	input  logic [cpu_pkg::data_w-1:0]  host_wdata,
	output logic [cpu_pkg::data_w-1:0]  host_rdata,
	output logic                        host_rvalid,
	input  logic                        start,
	output logic                        halted,
	output logic [cpu_pkg::flags_w-1:0] flags
);

	logic                       core_req;
	logic                       core_we;
	logic [addr_w-1:0]          core_addr;
	logic [cpu_pkg::data_w-1:0] core_wdata;
	logic                       core_gnt;
	logic                       core_rvalid;
	logic                       mem_en;
	logic                       mem_we;
	logic [addr_w-1:0]          mem_addr;
	logic [cpu_pkg::data_w-1:0] mem_wdata;
	logic [cpu_pkg::data_w-1:0] mem_rdata;

	// both requestors see the shared read data, rvalid tells who owns it
	assign host_rdata = mem_rdata;

	core_ctrl #(
		.addr_w (addr_w)
	) core_i (
		.clk         (clk),
		.rst         (rst),
		.start       (start),
		.halted      (halted),
		.flags       (flags),
		.core_req    (core_req),
		.core_we     (core_we),
		.core_addr   (core_addr),
		.core_wdata  (core_wdata),
		.core_gnt    (core_gnt),
		.core_rvalid (core_rvalid),
		.mem_rdata   (mem_rdata)
	);

	mem_arbiter #(
		.addr_w (addr_w)
	) arbiter_i (
		.clk         (clk),
		.rst         (rst),
		.host_req    (host_req),
		.host_we     (host_we),
		.host_addr   (host_addr),
		.host_wdata  (host_wdata),
		.host_rvalid (host_rvalid),
		.core_req    (core_req),
		.core_we     (core_we),
		.core_addr   (core_addr),
		.core_wdata  (core_wdata),
		.core_gnt    (core_gnt),
		.core_rvalid (core_rvalid),
		.mem_en      (mem_en),
		.mem_we      (mem_we),
		.mem_addr    (mem_addr),
		.mem_wdata   (mem_wdata)
	);

	unified_mem #(
		.addr_w (addr_w)
	) mem_i (
		.clk       (clk),
		.mem_en    (mem_en),
		.mem_we    (mem_we),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_rdata (mem_rdata)
	);

endmodule

// ==== dv/cpu_tb.sv ====
`timescale 1ns/10ps

module cpu_tb;

	localparam int addr_w = 10;
	localparam int clk_period = 8;
	localparam int max_progs = 32;
	localparam int max_len = 16;
	localparam int worst_cycles = 200;
	localparam int timeout_ns = max_progs * worst_cycles * clk_period * 2;
	localparam logic [addr_w-1:0] result_base = 10'h0c0;
	localparam logic [addr_w-1:0] scratch_base = 10'h200;

	logic                        clk;
	logic                        rst;
	logic                        host_req;
	logic                        host_we;
	logic [addr_w-1:0]           host_addr;
	logic [cpu_pkg::data_w-1:0]  host_wdata;
	logic [cpu_pkg::data_w-1:0]  host_rdata;
	logic                        host_rvalid;
	logic                        start;
	logic                        halted;
	logic [cpu_pkg::flags_w-1:0] flags;

	// program table with expected result word and flags per entry
	logic [15:0] prog_mem [max_progs][max_len];
	int          prog_len [max_progs];
	logic [15:0] exp_word [max_progs];
	logic [2:0]  exp_flags [max_progs];
	int          n_built;
	logic [2:0]  model_flags;
	logic [15:0] scratch [4];

	cpu_top #(
		.addr_w (addr_w)
	) dut_i (
		.clk         (clk),
		.rst         (rst),
		.host_req    (host_req),
		.host_we     (host_we),
		.host_addr   (host_addr),
		.host_wdata  (host_wdata),
		.host_rdata  (host_rdata),
		.host_rvalid (host_rvalid),
		.start       (start),
		.halted      (halted),
		.flags       (flags)
	);

	always #(clk_period / 2) clk = ~clk;

	function automatic logic [15:0] reg_word(input cpu_pkg::opcode_e op, input logic [3:0] rd,
		input logic [3:0] rs);
		logic [7:0] code;
		code = op;
		return {code[7:4], rd, code[3:0], rs};
	endfunction

	function automatic logic [15:0] imm_word(input cpu_pkg::opcode_e op, input logic [3:0] rd,
		input logic [7:0] imm8);
		logic [7:0] code;
		code = op;
		return {code[7:4], rd, imm8};
	endfunction

	function automatic logic [15:0] sext8(input logic [7:0] v);
		return {{8{v[7]}}, v};
	endfunction

	function automatic logic [15:0] fill_word(input logic [addr_w-1:0] addr);
		return {addr[5:0], addr};
	endfunction

	function automatic logic [addr_w-1:0] result_addr(input int k);
		return result_base + addr_w'(k);
	endfunction

	// {zero, negative, borrow} of a - b
	function automatic logic [2:0] compare_flags(input logic [15:0] a, input logic [15:0] b);
		logic [15:0] diff;
		diff = a - b;
		return {diff == 16'h0000, diff[15], a < b};
	endfunction

	function automatic logic [15:0] reg_op_result(input cpu_pkg::opcode_e op,
		input logic [15:0] a, input logic [15:0] b);
		case (op)
			cpu_pkg::op_add: return a + b;
			cpu_pkg::op_sub: return a - b;
			cpu_pkg::op_mul: return a * b;
			cpu_pkg::op_and: return a & b;
			cpu_pkg::op_or:  return a | b;
			cpu_pkg::op_xor: return a ^ b;
			default:         return b;
		endcase
	endfunction

	function automatic logic [15:0] imm_op_result(input cpu_pkg::opcode_e op,
		input logic [15:0] a, input logic [7:0] imm8);
		case (op)
			cpu_pkg::op_addi: return a + sext8(imm8);
			cpu_pkg::op_subi: return a - sext8(imm8);
			cpu_pkg::op_muli: return a * sext8(imm8);
			cpu_pkg::op_andi: return a & {8'h00, imm8};
			cpu_pkg::op_ori:  return a | {8'h00, imm8};
			cpu_pkg::op_xori: return a ^ {8'h00, imm8};
			cpu_pkg::op_movi: return {8'h00, imm8};
			default:          return {imm8, a[7:0]};
		endcase
	endfunction

	task automatic value_mismatch(input string msg);
		$display("FAIL at %0t: %s", $time, msg);
		$display(">>> FAIL");
		$fatal(1, "value mismatch");
	endtask

	task automatic abort_run(input string msg);
		$display("%s (at %0t)", msg, $time);
		$display(">>> FAIL");
		$fatal(1, "run aborted");
	endtask

	task automatic check_word(input logic [cpu_pkg::data_w-1:0] got,
		input logic [cpu_pkg::data_w-1:0] exp, input string what);
		if (got !== exp)
			value_mismatch($sformatf("%s is %h, expected %h", what, got, exp));
	endtask

	task automatic check_flags(input logic [cpu_pkg::flags_w-1:0] got,
		input logic [cpu_pkg::flags_w-1:0] exp, input string what);
		if (got !== exp)
			value_mismatch($sformatf("%s flags are %b, expected %b", what, got, exp));
	endtask

	task automatic check_halt(input logic got, input logic exp, input string what);
		if (got !== exp)
			value_mismatch($sformatf("halted is %b %s, expected %b", got, what, exp));
	endtask

	task automatic emit(input logic [15:0] word);
		prog_mem[n_built][prog_len[n_built]] = word;
		prog_len[n_built] = prog_len[n_built] + 1;
	endtask

	// full 16-bit constant through MOVI then LUI
	task automatic load16(input logic [3:0] rd, input logic [15:0] value);
		emit(imm_word(cpu_pkg::op_movi, rd, value[7:0]));
		emit(imm_word(cpu_pkg::op_lui, rd, value[15:8]));
	endtask

	task automatic close_prog(input logic [15:0] exp);
		exp_word[n_built] = exp;
		exp_flags[n_built] = model_flags;
		n_built = n_built + 1;
	endtask

	task automatic store_result(input logic [3:0] src, input logic [15:0] exp);
		logic [addr_w-1:0] addr;
		addr = result_addr(n_built);
		emit(imm_word(cpu_pkg::op_movi, 4'd4, addr[7:0]));
		emit(reg_word(cpu_pkg::op_store, src, 4'd4));
		emit(cpu_pkg::halt_word);
		close_prog(exp);
	endtask

	task automatic shift_case(input cpu_pkg::opcode_e op, input logic [15:0] a,
		input logic [7:0] amt, input logic [15:0] exp);
		load16(4'd1, a);
		emit(imm_word(cpu_pkg::op_movi, 4'd2, amt));
		emit(reg_word(op, 4'd1, 4'd2));
		store_result(4'd1, exp);
	endtask

	task automatic build_table();
		cpu_pkg::opcode_e  reg_ops [7];
		cpu_pkg::opcode_e  imm_ops [8];
		logic [15:0]       a;
		logic [15:0]       b;
		logic signed [15:0] sa;
		logic [7:0]        imm;
		logic [7:0]        offset;
		logic [addr_w-1:0] addr;
		reg_ops = '{cpu_pkg::op_add, cpu_pkg::op_sub, cpu_pkg::op_mul, cpu_pkg::op_and,
			cpu_pkg::op_or, cpu_pkg::op_xor, cpu_pkg::op_mov};
		imm_ops = '{cpu_pkg::op_addi, cpu_pkg::op_subi, cpu_pkg::op_muli, cpu_pkg::op_andi,
			cpu_pkg::op_ori, cpu_pkg::op_xori, cpu_pkg::op_movi, cpu_pkg::op_lui};
		n_built = 0;
		model_flags = 3'b000;
		for (int i = 0; i < max_progs; i++)
			prog_len[i] = 0;
		for (int i = 0; i < 7; i++)
		begin
			a = 16'($urandom);
			b = 16'($urandom);
			load16(4'd1, a);
			load16(4'd2, b);
			emit(reg_word(reg_ops[i], 4'd1, 4'd2));
			store_result(4'd1, reg_op_result(reg_ops[i], a, b));
		end
		// top bit of the byte set so sign and zero extension differ
		for (int i = 0; i < 8; i++)
		begin
			a = 16'($urandom);
			imm = 8'($urandom) | 8'h80;
			load16(4'd1, a);
			emit(imm_word(imm_ops[i], 4'd1, imm));
			store_result(4'd1, imm_op_result(imm_ops[i], a, imm));
		end
		a = 16'($urandom);
		shift_case(cpu_pkg::op_lsh, a, 8'h03, a << 3);
		a = 16'($urandom);
		shift_case(cpu_pkg::op_lsh, a, 8'hfb, a >> 5);
		a = 16'($urandom) | 16'h8000;
		sa = a;
		shift_case(cpu_pkg::op_ashu, a, 8'h1c, sa >>> 4);
		a = 16'($urandom);
		shift_case(cpu_pkg::op_ashu, a, 8'h02, a << 2);
		a = 16'($urandom);
		load16(4'd1, a);
		emit(imm_word(cpu_pkg::op_lshi, 4'd1, 8'h07));
		store_result(4'd1, a << 7);
		a = 16'($urandom);
		load16(4'd1, a);
		emit(imm_word(cpu_pkg::op_lshi, 4'd1, 8'h1e));
		store_result(4'd1, a >> 2);
		// compares, rd is stored to show it is unchanged
		a = 16'($urandom);
		b = 16'($urandom);
		load16(4'd1, a);
		load16(4'd2, b);
		emit(reg_word(cpu_pkg::op_cmp, 4'd1, 4'd2));
		model_flags = compare_flags(a, b);
		store_result(4'd1, a);
		a = 16'($urandom);
		load16(4'd1, a);
		load16(4'd2, a);
		emit(reg_word(cpu_pkg::op_cmp, 4'd1, 4'd2));
		model_flags = compare_flags(a, a);
		store_result(4'd1, a);
		a = 16'($urandom);
		imm = 8'($urandom) | 8'h80;
		load16(4'd1, a);
		emit(imm_word(cpu_pkg::op_cmpi, 4'd1, imm));
		model_flags = compare_flags(a, sext8(imm));
		store_result(4'd1, a);
		// store to a computed address, then load it back
		a = 16'($urandom);
		offset = 8'($urandom) & 8'h1f;
		load16(4'd1, a);
		emit(imm_word(cpu_pkg::op_movi, 4'd5, 8'h60));
		emit(imm_word(cpu_pkg::op_addi, 4'd5, offset));
		emit(reg_word(cpu_pkg::op_store, 4'd1, 4'd5));
		emit(reg_word(cpu_pkg::op_load, 4'd3, 4'd5));
		store_result(4'd3, a);
		// a store placed after the halt word must never land
		a = 16'($urandom);
		addr = result_addr(n_built);
		load16(4'd1, a);
		emit(imm_word(cpu_pkg::op_movi, 4'd4, addr[7:0]));
		emit(cpu_pkg::halt_word);
		emit(reg_word(cpu_pkg::op_store, 4'd1, 4'd4));
		close_prog(fill_word(addr));
	endtask

	task automatic host_write(input logic [addr_w-1:0] addr, input logic [15:0] data);
		@(posedge clk);
		host_req <= 1'b1;
		host_we <= 1'b1;
		host_addr <= addr;
		host_wdata <= data;
	endtask

	task automatic host_read(input logic [addr_w-1:0] addr, output logic [15:0] data);
		@(posedge clk);
		host_req <= 1'b1;
		host_we <= 1'b0;
		host_addr <= addr;
		@(posedge clk);
		host_req <= 1'b0;
		@(negedge clk);
		if (!host_rvalid)
			abort_run("host read got no rvalid strobe one cycle after its grant");
		else
			data = host_rdata;
	endtask

	task automatic pulse_start();
		@(posedge clk);
		host_req <= 1'b0;
		host_we <= 1'b0;
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
	endtask

	task automatic wait_halted();
		@(negedge clk);
		while (!halted)
			@(negedge clk);
	endtask

	initial
	begin
		#(timeout_ns);
		abort_run("timeout: the core never halted");
	end

	initial
	begin
		logic [15:0] got;
		clk = 1'b0;
		rst = 1'b1;
		host_req = 1'b0;
		host_we = 1'b0;
		host_addr = '0;
		host_wdata = '0;
		start = 1'b0;
		void'($urandom(84));
		build_table();
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check_halt(halted, 1'b1, "after reset");
		check_flags(flags, 3'b000, "after reset");
		for (int k = 0; k < n_built; k++)
		begin
			for (int i = 0; i < prog_len[k]; i++)
				host_write(addr_w'(i), prog_mem[k][i]);
			host_write(result_addr(k), fill_word(result_addr(k)));
			// odd entries run with host reads competing for the memory
			if (k % 2 == 1)
			begin
				for (int j = 0; j < 4; j++)
				begin
					scratch[j] = 16'($urandom);
					host_write(scratch_base + addr_w'(j), scratch[j]);
				end
			end
			pulse_start();
			@(negedge clk);
			check_halt(halted, 1'b0, $sformatf("after start of program %0d", k));
			if (k % 2 == 1)
			begin
				for (int j = 0; j < 4; j++)
				begin
					host_read(scratch_base + addr_w'(j), got);
					check_word(got, scratch[j], $sformatf("program %0d host read %0d", k, j));
				end
			end
			wait_halted();
			host_read(result_addr(k), got);
			check_word(got, exp_word[k], $sformatf("program %0d result word", k));
			check_flags(flags, exp_flags[k], $sformatf("program %0d", k));
		end
		$display(">>> PASS");
		$finish;
	end

endmodule

// ==== build.f ====
hw/cpu_pkg.sv
hw/instr_decoder.sv
hw/alu.sv
hw/reg_file.sv
hw/core_ctrl.sv
hw/mem_arbiter.sv
hw/unified_mem.sv
hw/cpu_top.sv
dv/cpu_tb.sv

// ==== Bender.yml ====
package:
  name: cpu16

sources:
  - hw/cpu_pkg.sv
  - hw/instr_decoder.sv
  - hw/alu.sv
  - hw/reg_file.sv
  - hw/core_ctrl.sv
  - hw/mem_arbiter.sv
  - hw/unified_mem.sv
  - hw/cpu_top.sv
  - target: test
    files:
      - dv/cpu_tb.sv
